/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the drawer testbench with Verilator

rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 --top-module drawer_tb -f sources.f -o Vdrawer_tb \
	|| { echo "Verilator build failed"; exit 1; }

# Let assertion errors continue so the testbench prints the result line
./obj_dir/Vdrawer_tb +verilator+error+limit+100 > sim.log 2>&1 \
	|| echo "Simulator exited with an error" >> sim.log
cat sim.log

grep -q "Result: FAILED" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "Result: PASSED" sim.log || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation passed"

/* sources.f */
src/video_pkg.sv
src/palette_pkg.sv
src/frame_fetch.sv
src/nibble_unpack.sv
src/color_mapper.sv
src/drawer_top.sv
verif/sram_model.sv
verif/drawer_chk.sv
verif/drawer_tb.sv

/* src/color_mapper.sv */
`timescale 1ns/1ps

module color_mapper (
	input  logic                    vgaClkIn,
	input  logic                    reset,
	input  palette_pkg::color_idx_t pix_idx,
	input  logic                    pix_valid,
	output palette_pkg::channel_t   red,
	output palette_pkg::channel_t   green,
	output palette_pkg::channel_t   blue,
	output logic                    pixel_en
);

	import palette_pkg::*;

	logic [23:0] rgb;

	assign rgb = PALETTE[pix_idx];

	always_ff @(posedge vgaClkIn) begin
		if (!reset) begin
			red      <= '0;
			green    <= '0;
			blue     <= '0;
			pixel_en <= 1'b0;
		end else begin
			pixel_en <= pix_valid;
			if (pix_valid) begin
				red   <= rgb[23:16];
				green <= rgb[15:8];
				blue  <= rgb[7:0];
			end else begin
				// Blank between frames
				red   <= '0;
				green <= '0;
				blue  <= '0;
			end
		end
	end

endmodule

/* src/drawer_top.sv */
`timescale 1ns/1ps

module drawer_top (
	input  logic                   vgaClkIn,
	input  logic                   reset,
	// Blitter handshake
	input  logic                   enable,
	input  logic                   ack_back,
	output logic                   acknowledge,
	output logic                   blitter_start,
	output logic                   in_control,
	// Video timing
	input  logic                   vsync,
	output logic                   vga_reset,
	// Async SRAM, read only
	input  video_pkg::sram_word_t  sram_dq,
	output video_pkg::sram_addr_t  sram_addr,
	output logic                   sram_ce_n,
	output logic                   sram_oe_n,
	// Pixel stream
	output palette_pkg::channel_t  red,
	output palette_pkg::channel_t  green,
	output palette_pkg::channel_t  blue,
	output logic                   pixel_en
);

	import video_pkg::*;
	import palette_pkg::*;

	pix_byte_t  byte_data;
	logic       byte_valid;
	color_idx_t pix_idx;
	logic       pix_valid;

	frame_fetch u_fetch (
		.vgaClkIn      (vgaClkIn),
		.reset         (reset),
		.enable        (enable),
		.ack_back      (ack_back),
		.vsync         (vsync),
		.sram_dq       (sram_dq),
		.acknowledge   (acknowledge),
		.blitter_start (blitter_start),
		.in_control    (in_control),
		.vga_reset     (vga_reset),
		.sram_addr     (sram_addr),
		.sram_ce_n     (sram_ce_n),
		.sram_oe_n     (sram_oe_n),
		.byte_data     (byte_data),
		.byte_valid    (byte_valid)
	);

	nibble_unpack u_unpack (
		.vgaClkIn   (vgaClkIn),
		.reset      (reset),
		.byte_data  (byte_data),
		.byte_valid (byte_valid),
		.pix_idx    (pix_idx),
		.pix_valid  (pix_valid)
	);

	color_mapper u_mapper (
		.vgaClkIn  (vgaClkIn),
		.reset     (reset),
		.pix_idx   (pix_idx),
		.pix_valid (pix_valid),
		.red       (red),
		.green     (green),
		.blue      (blue),
		.pixel_en  (pixel_en)
	);

endmodule

/* src/frame_fetch.sv */
`timescale 1ns/1ps

module frame_fetch (
	input  logic                   vgaClkIn,
	input  logic                   reset,
	input  logic                   enable,		// Blitter done, frame may start
	input  logic                   ack_back,	// Blitter has taken over
	input  logic                   vsync,
	input  video_pkg::sram_word_t  sram_dq,
	output logic                   acknowledge,
	output logic                   blitter_start,
	output logic                   in_control,
	output logic                   vga_reset,
	output video_pkg::sram_addr_t  sram_addr,
	output logic                   sram_ce_n,
	output logic                   sram_oe_n,
	output video_pkg::pix_byte_t   byte_data,
	output logic                   byte_valid
);

	import video_pkg::*;

	fetch_state_t state, next_state;

	sram_addr_t addr;			// Byte being scanned
	sram_addr_t row_start;		// Rewind point for repeated rows
	logic [3:0] cyc;			// Position inside the byte period
	logic [8:0] byte_cnt;		// Byte within the stored row
	logic [2:0] rep_cnt;		// Times the current row has been shown, minus one

	logic last_cyc;
	logic row_end;
	logic rep_end;

	assign last_cyc = (cyc == 4'(2 * PIXEL_CYCLES - 1));
	assign row_end  = (byte_cnt == ROW_BYTES - 9'd1);
	assign rep_end  = (rep_cnt == LINE_REPEAT - 3'd1);

	always_ff @(posedge vgaClkIn) begin
		if (!reset) begin
			state <= IDLE;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			IDLE: begin
				if (enable)
					next_state = GRANT;
			end
			GRANT:   next_state = SYNC;
			SYNC:    next_state = FETCH;
			FETCH: begin
				if (last_cyc && vsync)	// Frame ends only on a byte boundary
					next_state = RELEASE;
			end
			RELEASE: begin
				if (ack_back)
					next_state = IDLE;
			end
			default: next_state = IDLE;
		endcase
	end

	// Address generation and counters
	always_ff @(posedge vgaClkIn) begin
		if (!reset) begin
			addr      <= BUFFER_START;
			row_start <= BUFFER_START;
			cyc       <= '0;
			byte_cnt  <= '0;
			rep_cnt   <= '0;
		end else if (state == SYNC) begin
			addr      <= BUFFER_START;
			row_start <= BUFFER_START;
			cyc       <= '0;
			byte_cnt  <= '0;
			rep_cnt   <= '0;
		end else if (state == FETCH) begin
			if (!last_cyc) begin
				cyc <= cyc + 4'd1;
			end else begin
				cyc <= '0;
				if (!row_end) begin
					addr     <= addr + 20'd1;
					byte_cnt <= byte_cnt + 9'd1;
				end else begin
					byte_cnt <= '0;
					if (rep_end) begin		// Row done, step to the next one
						rep_cnt   <= '0;
						addr      <= addr + 20'd1;
						row_start <= addr + 20'd1;
					end else begin
						rep_cnt <= rep_cnt + 3'd1;
						addr    <= row_start;	// Show the same row again
					end
				end
			end
		end
	end

	// SRAM read data is sampled at the end of the address cycle
	always_ff @(posedge vgaClkIn) begin
		if (state == FETCH && cyc == 4'd0)
			byte_data <= sram_dq[7:0];
	end

	always_ff @(posedge vgaClkIn) begin
		if (!reset) begin
			byte_valid <= 1'b0;
		end else begin
			byte_valid <= (state == FETCH) && (cyc == 4'd0);
		end
	end

	// Handshake levels decoded from the state
	assign acknowledge   = (state == GRANT);
	assign vga_reset     = (state == SYNC);
	assign blitter_start = (state == RELEASE);
	assign in_control    = (state == GRANT) || (state == SYNC) || (state == FETCH);

	// Bus is released whenever the blitter may own the SRAM
	assign sram_addr = in_control ? addr : '0;
	assign sram_ce_n = ~in_control;
	assign sram_oe_n = ~in_control;

endmodule

/* src/nibble_unpack.sv */
`timescale 1ns/1ps

module nibble_unpack (
	input  logic                  vgaClkIn,
	input  logic                  reset,
	input  video_pkg::pix_byte_t  byte_data,
	input  logic                  byte_valid,
	output palette_pkg::color_idx_t pix_idx,
	output logic                  pix_valid
);

	import video_pkg::*;

	pix_byte_t  data_q;		// Byte currently on screen
	logic [3:0] cnt;		// Cycles the current nibble has been held
	logic       half;		// 0 upper nibble, 1 lower nibble

	logic pix_last;

	assign pix_last = (cnt == PIXEL_CYCLES - 4'd1);

	always_ff @(posedge vgaClkIn) begin
		if (byte_valid)
			data_q <= byte_data;
	end

	always_ff @(posedge vgaClkIn) begin
		if (!reset) begin
			cnt       <= '0;
			half      <= 1'b0;
			pix_valid <= 1'b0;
		end else if (byte_valid) begin
			// A new byte always wins, so back to back bytes leave no gap
			cnt       <= '0;
			half      <= 1'b0;
			pix_valid <= 1'b1;
		end else if (pix_valid) begin
			if (!pix_last) begin
				cnt <= cnt + 4'd1;
			end else begin
				cnt <= '0;
				if (half)
					pix_valid <= 1'b0;	// Byte used up
				else
					half <= 1'b1;
			end
		end
	end

	// Left pixel sits in the upper nibble
	assign pix_idx = half ? data_q[3:0] : data_q[7:4];

endmodule

/* src/palette_pkg.sv */
package palette_pkg;

	typedef logic [3:0] color_idx_t;	// One pixel as stored in the framebuffer
	typedef logic [7:0] channel_t;		// One of red, green or blue

	// 16 colour palette, each entry packed as {red, green, blue}
	localparam logic [23:0] PALETTE [0:15] = '{
		24'h00_00_00,	// 0 black
		24'h00_80_ff,	// 1 royal blue
		24'h00_00_ff,	// 2 dark blue
		24'h00_ff_ff,	// 3 cyan
		24'h66_66_66,	// 4 grey
		24'h00_ff_00,	// 5 green
		24'h80_80_00,	// 6 olive
		24'h00_00_80,	// 7 navy
		24'h18_fa_92,	// 8 sea green
		24'hff_ff_ff,	// 9 white
		24'hff_93_00,	// 10 orange
		24'hff_00_00,	// 11 red
		24'h80_ff_00,	// 12 lime
		24'hff_ff_00,	// 13 yellow
		24'h80_00_00,	// 14 maroon
		24'hff_66_66	// 15 pink
	};

endpackage

/* src/video_pkg.sv */
package video_pkg;

	// SRAM side of the framebuffer
	typedef logic [19:0] sram_addr_t;	// Word address
	typedef logic [15:0] sram_word_t;	// Data bus, low byte carries pixels
	typedef logic [7:0]  pix_byte_t;	// Two packed 4-bit pixels

	// Where the image lives in SRAM
	localparam sram_addr_t BUFFER_START = 20'd0;

	// Stored row length in bytes (two pixels per byte)
	localparam logic [8:0] ROW_BYTES = 9'd128;

	// Vertical scaling, every stored row is scanned this many times
	localparam logic [2:0] LINE_REPEAT = 3'd4;

	// Clocks per displayed pixel
	// A byte period is twice this
	localparam logic [3:0] PIXEL_CYCLES = 4'd5;

	// Scan-out FSM
	typedef enum logic [2:0] {
		IDLE,		// Waiting for the blitter to hand over
		GRANT,		// Acknowledge pulse, SRAM taken
		SYNC,		// Resync the video timing, load the first address
		FETCH,		// Byte periods until vsync
		RELEASE		// Start the blitter, wait for ack_back
	} fetch_state_t;

endpackage

/* verif/drawer_chk.sv */
`timescale 1ns/1ps

module drawer_chk (
	input logic                    vgaClkIn,
	input logic                    reset,
	input logic                    enable,
	input logic                    ack_back,
	input logic                    acknowledge,
	input logic                    blitter_start,
	input logic                    in_control,
	input logic                    vga_reset,
	input video_pkg::sram_addr_t   sram_addr,
	input logic                    sram_ce_n,
	input logic                    sram_oe_n,
	input palette_pkg::color_idx_t pix_idx,
	input logic                    pix_valid,
	input palette_pkg::channel_t   red,
	input palette_pkg::channel_t   green,
	input palette_pkg::channel_t   blue,
	input logic                    pixel_en
);

	import video_pkg::*;
	import palette_pkg::*;

	int unsigned fail_count = 0;	// Watched by the testbench

	a_reset_idle: assert property (@(posedge vgaClkIn) $rose(reset) |->
		!acknowledge && !blitter_start && !in_control && !vga_reset && !pixel_en)
	else begin
		$error("Control outputs not idle when reset is released");
		fail_count++;
	end

	// SRAM pins follow ownership
	a_sram_pins: assert property (@(posedge vgaClkIn) disable iff (!reset)
		sram_ce_n == !in_control && sram_oe_n == !in_control && (in_control || sram_addr == '0))
	else begin
		$error("SRAM pins do not match in_control");
		fail_count++;
	end

	a_ack_cause: assert property (@(posedge vgaClkIn) disable iff (!reset)
		$rose(acknowledge) |-> $past(enable))
	else begin
		$error("acknowledge rose without enable");
		fail_count++;
	end

	// One cycle pulse, then the sync cycle
	a_ack_pulse: assert property (@(posedge vgaClkIn) disable iff (!reset)
		acknowledge |=> !acknowledge && vga_reset)
	else begin
		$error("acknowledge is not a single pulse followed by vga_reset");
		fail_count++;
	end

	a_sync_pulse: assert property (@(posedge vgaClkIn) disable iff (!reset)
		vga_reset |=> !vga_reset && in_control && sram_addr == BUFFER_START)
	else begin
		$error("Scan did not start at BUFFER_START after one vga_reset cycle");
		fail_count++;
	end

	a_first_pixel: assert property (@(posedge vgaClkIn) disable iff (!reset)
		vga_reset |=> !pixel_en ##1 !pixel_en ##1 !pixel_en ##1 pixel_en)
	else begin
		$error("First pixel_en not 3 edges after the first address cycle");
		fail_count++;
	end

	a_start_held: assert property (@(posedge vgaClkIn) disable iff (!reset)
		blitter_start && !ack_back |=> blitter_start)
	else begin
		$error("blitter_start dropped before ack_back");
		fail_count++;
	end

	a_start_done: assert property (@(posedge vgaClkIn) disable iff (!reset)
		blitter_start && ack_back |=> !blitter_start && !in_control)
	else begin
		$error("blitter_start still high after ack_back");
		fail_count++;
	end

	a_palette: assert property (@(posedge vgaClkIn) disable iff (!reset)
		pix_valid |=> pixel_en && {red, green, blue} == PALETTE[$past(pix_idx)])
	else begin
		$error("RGB does not match the palette entry of the previous index");
		fail_count++;
	end

endmodule

bind drawer_top drawer_chk chk (.*);

/* verif/drawer_tb.sv */
`timescale 1ns/1ps

module drawer_tb;

	import video_pkg::*;
	import palette_pkg::*;

	localparam int IMAGE_WORDS  = 1024;
	localparam int BYTE_CYCLES  = 2 * 32'(PIXEL_CYCLES);
	localparam int FRAME1_BYTES = 2 * 32'(ROW_BYTES) * 32'(LINE_REPEAT);	// Two full rows
	localparam int FRAME2_BYTES = 32'(ROW_BYTES) + 37;	// Ends inside a repeated row
	localparam int RUN_CYCLES   = (FRAME1_BYTES + FRAME2_BYTES) * BYTE_CYCLES + 200;
	localparam int ACK_DELAY    = 7;

	logic       vgaClkIn;
	logic       reset;
	logic       enable;
	logic       ack_back;
	logic       vsync;
	sram_word_t sram_dq;
	sram_addr_t sram_addr;
	logic       sram_ce_n;
	logic       sram_oe_n;
	logic       acknowledge;
	logic       blitter_start;
	logic       in_control;
	logic       vga_reset;
	channel_t   red;
	channel_t   green;
	channel_t   blue;
	logic       pixel_en;

	pix_byte_t   image [0:IMAGE_WORDS-1];	// Pixel bytes as loaded into the SRAM
	logic [31:0] lfsr;
	int unsigned shown = 0;			// Pixel clocks seen in this frame
	int unsigned frame_bytes = 0;
	logic        pixel_en_q = 1'b0;

	drawer_top DUT (.*);

	sram_model sram (
		.addr (sram_addr),
		.ce_n (sram_ce_n),
		.oe_n (sram_oe_n),
		.dq   (sram_dq)
	);

	// Galois form of x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// Palette index on screen at a given pixel clock of the frame
	function automatic color_idx_t expected_index(input int unsigned clk_no);
		int unsigned pixel;
		int unsigned byte_no;
		logic [31:0] addr;
		pixel   = clk_no / 32'(PIXEL_CYCLES);
		byte_no = pixel / 2;
		addr    = 32'(BUFFER_START)
			+ (byte_no / (32'(ROW_BYTES) * 32'(LINE_REPEAT))) * 32'(ROW_BYTES)
			+ byte_no % 32'(ROW_BYTES);
		return pixel[0] ? image[addr[9:0]][3:0] : image[addr[9:0]][7:4];	// Upper nibble first
	endfunction

	task automatic flag_mismatch(input string what);
		$display("[FAIL] %0d ns: %s", $time, what);
		$display("Result: FAILED");
		$fatal(1, "Stopping at the first error");
	endtask

	// Handshake for one frame, vsync held for the last hold cycles of byte n_bytes-1
	task automatic run_frame(input int n_bytes, input int hold);
		frame_bytes = n_bytes;
		@(posedge vgaClkIn);
		enable <= 1'b1;
		@(posedge vgaClkIn);
		enable <= 1'b0;
		@(negedge vgaClkIn);
		while (!vga_reset)
			@(negedge vgaClkIn);
		repeat (n_bytes * BYTE_CYCLES - hold + 1) @(posedge vgaClkIn);
		vsync <= 1'b1;
		repeat (hold) @(posedge vgaClkIn);
		vsync <= 1'b0;
		while (!blitter_start)
			@(negedge vgaClkIn);
		repeat (ACK_DELAY) @(posedge vgaClkIn);	// Blitter answers late
		ack_back <= 1'b1;
		@(posedge vgaClkIn);
		ack_back <= 1'b0;
	endtask

	initial begin
		vgaClkIn = 1'b0;
		forever #5 vgaClkIn = ~vgaClkIn;
	end

	initial begin
		sram_word_t word;
		reset    = 1'b0;
		enable   = 1'b0;
		ack_back = 1'b0;
		vsync    = 1'b0;
		lfsr     = 32'h22b3_0215;
		for (int a = 0; a < IMAGE_WORDS; a++) begin
			word = '0;
			for (int b = 0; b < 16; b++) begin
				word = {word[14:0], lfsr[0]};
				lfsr = lfsr_next(lfsr);
			end
			sram.mem[a[9:0]] = word;
			image[a[9:0]]    = word[7:0];
		end
		repeat (16) @(posedge vgaClkIn);
		reset <= 1'b1;
		@(negedge vgaClkIn);
		assert (!acknowledge && !blitter_start && !in_control && !vga_reset && !pixel_en
			&& sram_ce_n && sram_oe_n && sram_addr == '0)
		else flag_mismatch("outputs not idle after reset");
		run_frame(FRAME1_BYTES, 1);
		run_frame(FRAME2_BYTES, 4);	// vsync rises mid byte as well
		repeat (20) @(posedge vgaClkIn);
		if (DUT.chk.fail_count == 0) begin
			$display("Result: PASSED");
			$finish;
		end else begin
			$display("Result: FAILED");
			$fatal(1, "Bound checker reported errors");
		end
	end

	// Pixel stream against the image
	always @(negedge vgaClkIn) begin
		if (vga_reset) begin
			shown = 0;
		end else if (pixel_en) begin
			assert ({red, green, blue} == PALETTE[expected_index(shown)])
			else flag_mismatch($sformatf("pixel clock %0d shows %06h, expected %06h",
				shown, {red, green, blue}, PALETTE[expected_index(shown)]));
			shown++;
		end else if (reset) begin
			assert ({red, green, blue} == 24'h0)
			else flag_mismatch("RGB not black while pixel_en is low");
			if (pixel_en_q)	// Frame just ended
				assert (shown == frame_bytes * BYTE_CYCLES)
				else flag_mismatch($sformatf("frame showed %0d pixel clocks, expected %0d",
					shown, frame_bytes * BYTE_CYCLES));
		end
		pixel_en_q = pixel_en;
	end

	always @(negedge vgaClkIn) begin
		if (DUT.chk.fail_count != 0) begin
			$display("A bound assertion on the handshake, SRAM or RGB pins failed");
			$display("Result: FAILED");
			$fatal(1, "Checker error");
		end
	end

	initial begin
		repeat (RUN_CYCLES + 16) @(posedge vgaClkIn);
		$display("Timeout: the two frames did not finish within %0d cycles", RUN_CYCLES);
		$display("Result: FAILED");
		$fatal(1, "Watchdog expired");
	end

endmodule

/* verif/sram_model.sv */
`timescale 1ns/1ps

module sram_model (
	input  video_pkg::sram_addr_t addr,
	input  logic                  ce_n,
	input  logic                  oe_n,
	output video_pkg::sram_word_t dq
);

	import video_pkg::*;

	localparam int DEPTH = 1024;

	sram_word_t mem [0:DEPTH-1];	// Loaded by the testbench at time zero

	// Asynchronous read, bus reads as zero when deselected or out of range
	assign dq = (!ce_n && !oe_n && addr < 20'(DEPTH)) ? mem[addr[9:0]] : '0;

endmodule
